// ==== common/blaster_pkg.sv ====
package blaster_pkg;

	//////////////////////////////////////////////////////////////////////
	// adc words
	//////////////////////////////////////////////////////////////////////

	// offset coded converter word
	typedef struct packed {
		logic        neg;   // set for negative readings
		logic [10:0] mag_n; // magnitude, inverted
	} adc_fields_t;

	typedef union packed {
		logic [11:0] raw;
		adc_fields_t f;
	} adc_word_u;

	// positive magnitude, negative clips to zero
	function automatic logic [10:0] adc_magnitude(input adc_word_u w);
		return w.f.neg ? 11'd0 : ~w.f.mag_n;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// keypad codes
	//////////////////////////////////////////////////////////////////////

	typedef logic [4:0] key_code_t; // bit 4 pressed, 3:0 index

	localparam key_code_t KEY_CHARGE     = 5'h1A;
	localparam key_code_t KEY_DUMP       = 5'h1B;
	localparam key_code_t KEY_TONE_FIRST = 5'h11;
	localparam key_code_t KEY_TONE_LAST  = 5'h18;

	// half period reloads for keys 11..18
	localparam logic [0:7][15:0] TONE_HALF = {
		16'h2CCA, 16'h27E7, 16'h238D, 16'h218E,
		16'h1DE5, 16'h1AA2, 16'h17BA, 16'h1665
	};

	// analog levels in adc counts
	localparam logic [11:0] DN_PER_AMP    = 12'd205;
	localparam logic [11:0] CUR_HYST      = 12'd20;  // about 10% of 1 A
	localparam logic [11:0] CUR_SEEN      = 12'd100; // half an amp
	localparam logic [11:0] CUR_LOW       = 12'd32;
	localparam logic [11:0] VCAP_MIN      = 12'd256; // 50 V
	localparam logic [11:0] DV_LIMIT      = 12'd40;  // rise per sample at burn
	localparam logic [11:0] VCAP_ARM_ON   = 12'd1496; // 300 V
	localparam logic [11:0] VCAP_ARM_OFF  = 12'd249;  // 50 V

	// pulse timing at 48 MHz
	localparam logic [15:0] PULSE_MIN_ON  = 16'd32;
	localparam logic [15:0] PULSE_MAX_ON  = 16'd768; // 16 us
	localparam logic [15:0] PULSE_MIN_OFF = 16'd192; // 4 us

	localparam int FIRE_CNT_W = 28;
	localparam int KEY_DIV_W  = 12;

endpackage

// ==== common/adc_if.sv ====
`timescale 1ns/1ps

interface adc_if import blaster_pkg::*; ();

	adc_word_u iout;   // a0 output current
	adc_word_u vcap;   // a1 cap voltage
	adc_word_u vout;   // b1 output voltage
	logic      strobe; // new sample this cycle

	modport source (
		output iout, vcap, vout, strobe
	);

	// words hold between strobes
	modport monitor (
		input iout, vcap, vout, strobe
	);

endinterface

// ==== src/fire_sequencer.sv ====
`timescale 1ns/1ps

module fire_sequencer import blaster_pkg::*; #(
	parameter int unsigned DEBOUNCE_CYC = 480000,
	parameter int unsigned STEP_CYC     = 524288,
	parameter int unsigned FIRE_END_CYC = 64000000
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       fire_button,
	input  logic       lt3420_done,
	input  logic [2:0] iset,          // active low switches
	input  key_code_t  key,
	adc_if.monitor     adc,
	output logic       fire_flag,
	output logic       setpoint_high,
	output logic       lt3420_charge,
	output logic       dump,
	output logic       arm_led
);

	localparam logic [FIRE_CNT_W-1:0] CNT_DEBOUNCE = FIRE_CNT_W'(DEBOUNCE_CYC);
	localparam logic [FIRE_CNT_W-1:0] CNT_START    = FIRE_CNT_W'(DEBOUNCE_CYC + 1);
	localparam logic [FIRE_CNT_W-1:0] CNT_STEP     = FIRE_CNT_W'(STEP_CYC);
	localparam logic [FIRE_CNT_W-1:0] CNT_END      = FIRE_CNT_W'(FIRE_END_CYC);

	logic [FIRE_CNT_W-1:0] fire_count;
	logic                  fire_done;  // window over, cap dumps
	logic                  charge;     // power on charge
	logic [10:0]           vcap_mag;

	assign vcap_mag = adc_magnitude(adc.vcap);

	//////////////////////////////////////////////////////////////////////
	// fire window

	always_ff @(posedge clk) begin
		if (reset) begin
			fire_count    <= '0;
			fire_flag     <= 1'b0;
			fire_done     <= 1'b0;
			setpoint_high <= 1'b0;
		end else begin
			// released button clears only while still debouncing
			fire_count <= (!fire_button && fire_count < CNT_DEBOUNCE) ? '0 : fire_count + 1'b1;
			if (fire_count == CNT_START && !fire_done)
				fire_flag <= 1'b1;
			else if (fire_count == CNT_END)
				fire_flag <= 1'b0;
			if (fire_count == CNT_END)
				fire_done <= 1'b1; // one shot per power up
			setpoint_high <= (fire_count >= CNT_STEP) && !fire_done; // 2 A then 4 A
		end
	end

	//////////////////////////////////////////////////////////////////////
	// power on charge

	always_ff @(posedge clk) begin
		if (reset)
			charge <= !iset[2]; // sw2 low enables auto charge
		else if (lt3420_done && charge)
			charge <= 1'b0;
	end

	assign lt3420_charge = charge || key == KEY_CHARGE;
	assign dump = fire_done || !iset[1] || key == KEY_DUMP; // sw1 forces dump

	// arm led with 300 V on and 50 V off
	always_ff @(posedge clk) begin
		if (reset)
			arm_led <= 1'b0;
		else if (adc.strobe && {1'b0, vcap_mag} > VCAP_ARM_ON)
			arm_led <= 1'b1;
		else if (adc.strobe && {1'b0, vcap_mag} < VCAP_ARM_OFF)
			arm_led <= 1'b0;
	end

	a_flag_not_done: assert property (@(posedge clk) disable iff (reset)
		!(fire_flag && fire_done));

endmodule

// ==== pulse/pulse_controller.sv ====
`timescale 1ns/1ps

module pulse_controller import blaster_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   fire_flag,
	input  logic   setpoint_high,
	input  logic   burn,
	adc_if.monitor adc,
	output logic   pwm
);

	logic [11:0] setpoint;
	logic [11:0] thresh_hi;  // stop pulse above
	logic [11:0] thresh_lo;  // start pulse below
	logic [11:0] iout_mag;
	logic [15:0] pulse_time; // on or off time so far

	// 2 A at start, 4 A after the step
	assign setpoint  = setpoint_high ? 12'(DN_PER_AMP << 2) : 12'(DN_PER_AMP << 1);
	assign thresh_hi = setpoint + CUR_HYST;
	assign thresh_lo = setpoint - CUR_HYST;
	assign iout_mag  = {1'b0, adc_magnitude(adc.iout)};

	//////////////////////////////////////////////////////////////////////
	// pulse generator

	always_ff @(posedge clk) begin
		if (reset) begin
			pwm        <= 1'b0;
			pulse_time <= '0;
		end else if (pwm) begin
			// an on pulse always runs to its end
			if (pulse_time < PULSE_MIN_ON) begin
				pulse_time <= pulse_time + 1'b1;
			end else if (burn || pulse_time >= PULSE_MAX_ON || iout_mag > thresh_hi) begin
				pwm        <= 1'b0;
				pulse_time <= '0;
			end else begin
				pulse_time <= pulse_time + 1'b1;
			end
		end else if (fire_flag && !burn) begin
			if (pulse_time < PULSE_MIN_OFF) begin
				pulse_time <= pulse_time + 1'b1; // min off time
			end else if (iout_mag < thresh_lo) begin
				pwm        <= 1'b1;
				pulse_time <= 16'd1;
			end else begin
				pulse_time <= pulse_time + 1'b1; // wait for current to decay
			end
		end else begin
			pulse_time <= '0; // idle
		end
	end

	// covers every path that ends a pulse
	a_max_on: assert property (@(posedge clk) disable iff (reset)
		$rose(pwm) |-> ##[1:PULSE_MAX_ON] !pwm);

endmodule

// ==== pulse/burn_detect.sv ====
`timescale 1ns/1ps

module burn_detect import blaster_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   fire_flag,
	adc_if.monitor adc,
	output logic   burn
);

	logic [11:0]        iout_mag;
	logic [11:0]        vcap_mag;
	logic [11:0]        vout_mag;
	logic [10:0]        vout_prev;    // vout at last strobe
	logic               current_seen; // igniter drew current
	logic signed [12:0] dv;           // vout rise per sample
	logic               open_circuit;

	assign iout_mag = {1'b0, adc_magnitude(adc.iout)};
	assign vcap_mag = {1'b0, adc_magnitude(adc.vcap)};
	assign vout_mag = {1'b0, adc_magnitude(adc.vout)};
	assign dv = $signed({1'b0, vout_mag}) - $signed({2'b00, vout_prev});

	// current gone or output at cap level with charge left
	assign open_circuit = current_seen && vcap_mag > VCAP_MIN &&
		(iout_mag < CUR_LOW || vout_mag > vcap_mag);

	always_ff @(posedge clk) begin
		if (reset) begin
			burn         <= 1'b0;
			current_seen <= 1'b0;
			vout_prev    <= '0;
		end else if (adc.strobe) begin
			vout_prev <= vout_mag[10:0];
			if (fire_flag && iout_mag > CUR_SEEN)
				current_seen <= 1'b1;
			// sticky until reset
			if (fire_flag && (dv > $signed({1'b0, DV_LIMIT}) || open_circuit))
				burn <= 1'b1;
		end
	end

endmodule

// ==== src/key_scan.sv ====
`timescale 1ns/1ps

module key_scan import blaster_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [2:0] keypad_col, // pulled low by a pressed key
	output logic [3:0] keypad_row, // one driven low at a time
	output key_code_t  key
);

	logic [KEY_DIV_W-1:0] div;
	logic [1:0]           row_sel;
	logic [2:0]           col;  // captured, active high
	logic [3:0]           row;
	logic                 flag; // key seen this scan

	assign row_sel = div[KEY_DIV_W-1 -: 2];

	// 4x3 layout, fire key 10 sits with the zero
	function automatic key_code_t decode(input logic [2:0] c, input logic [3:0] r);
		if (c == 3'b001)
			return r[0] ? 5'h13 : r[1] ? 5'h16 : r[2] ? 5'h19 : r[3] ? 5'h1B : 5'h00;
		else if (c[2:1] == 2'b01)
			return r[0] ? 5'h12 : r[1] ? 5'h15 : r[2] ? 5'h18 : r[3] ? 5'h10 : 5'h00;
		else if (c[2])
			return r[0] ? 5'h11 : r[1] ? 5'h14 : r[2] ? 5'h17 : r[3] ? 5'h1A : 5'h00;
		else
			return 5'h00;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// row driver and column sampler

	always_ff @(posedge clk) begin
		if (reset) begin
			div        <= '0;
			keypad_row <= 4'hF;
			col        <= '0;
			row        <= '0;
			flag       <= 1'b0;
			key        <= '0;
		end else begin
			div <= div + 1'b1;
			for (int i = 0; i < 4; i++)
				keypad_row[i] <= row_sel != 2'(i); // 1024 cycles per row
			if (div == '0) begin
				flag <= 1'b0; // new scan
			end else if (div == '1 && !flag) begin
				col <= '0; // nothing pressed all scan
				row <= '0;
			end else if (div[9:0] == 10'h3F0 && keypad_col != 3'b111) begin
				flag <= 1'b1; // sample late in the row
				col  <= ~keypad_col;
				row  <= ~keypad_row;
			end
			key <= decode(col, row);
		end
	end

	a_one_row: assert property (@(posedge clk) disable iff (reset)
		$onehot0(~keypad_row));

endmodule

// ==== src/tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen import blaster_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  key_code_t key,
	output logic      speaker,
	output logic      speaker_n
);

	logic [15:0] tone_cnt;
	logic        phase;
	logic        tone_key; // one of keys 11..18 held
	logic [2:0]  tone_idx;

	assign tone_key = key >= KEY_TONE_FIRST && key <= KEY_TONE_LAST;
	assign tone_idx = 3'(key - KEY_TONE_FIRST);

	// half period is reload plus one
	always_ff @(posedge clk) begin
		if (reset) begin
			tone_cnt <= '0;
			phase    <= 1'b0;
		end else if (!tone_key) begin
			tone_cnt <= '0;
			phase    <= 1'b0;
		end else if (tone_cnt == '0) begin
			phase    <= ~phase;
			tone_cnt <= TONE_HALF[tone_idx];
		end else begin
			tone_cnt <= tone_cnt - 1'b1;
		end
	end

	// differential drive doubles the swing
	assign speaker   = phase && tone_key;
	assign speaker_n = !speaker;

endmodule

// ==== src/blaster_top.sv ====
`timescale 1ns/1ps

module blaster_top import blaster_pkg::*; #(
	parameter int unsigned DEBOUNCE_CYC = 480000,   // 10 ms
	parameter int unsigned STEP_CYC     = 524288,   // setpoint step
	parameter int unsigned FIRE_END_CYC = 64000000  // 1.33 s window
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        fire_button,
	input  logic        lt3420_done,
	input  logic [2:0]  iset,
	input  logic [11:0] ad_iout,
	input  logic [11:0] ad_vcap,
	input  logic [11:0] ad_vout,
	input  logic        ad_strobe,
	input  logic [2:0]  keypad_col,
	output logic        pwm,
	output logic        dump,
	output logic        lt3420_charge,
	output logic        arm_led,
	output logic        speaker,
	output logic        speaker_n,
	output logic [3:0]  keypad_row
);

	logic      fire_flag;
	logic      setpoint_high;
	logic      burn;
	key_code_t key;

	//////////////////////////////////////////////////////////////////////
	// sampled adc channels

	adc_if adc ();

	assign adc.iout.raw = ad_iout;
	assign adc.vcap.raw = ad_vcap;
	assign adc.vout.raw = ad_vout;
	assign adc.strobe   = ad_strobe;

	fire_sequencer #(
		.DEBOUNCE_CYC (DEBOUNCE_CYC),
		.STEP_CYC     (STEP_CYC),
		.FIRE_END_CYC (FIRE_END_CYC)
	) u_fire (
		.clk, .reset, .fire_button, .lt3420_done, .iset, .key,
		.adc           (adc.monitor),
		.fire_flag, .setpoint_high, .lt3420_charge, .dump, .arm_led
	);

	pulse_controller u_pulse (
		.clk, .reset, .fire_flag, .setpoint_high, .burn,
		.adc (adc.monitor),
		.pwm
	);

	burn_detect u_burn (.clk, .reset, .fire_flag, .adc(adc.monitor), .burn);

	key_scan u_keys (.clk, .reset, .keypad_col, .keypad_row, .key);

	tone_gen u_tone (.clk, .reset, .key, .speaker, .speaker_n);

endmodule

// ==== dv/blaster_tb.sv ====
`timescale 1ns/1ps

module blaster_tb import blaster_pkg::*; ();

	localparam int DEB     = 100;
	localparam int STEP    = 3000;
	localparam int FEND    = 8000;
	localparam int SCAN    = 4096; // keypad scan length
	localparam int BURN_AT = 3500; // vout jump in burn run
	// tones, key waits, three firing runs
	localparam int SCN_LEN = 500 + 2 * (5 * SCAN + 3 * (32'h2CCA + 1)) + 12 * SCAN
		+ 3 * (FEND + 5000);
	localparam int TIMEOUT = 3 * SCN_LEN;

	logic        clk = 1'b0;
	logic        reset;
	logic        fire_button;
	logic        lt3420_done;
	logic        ad_strobe;
	logic [2:0]  iset;
	logic [2:0]  keypad_col;
	logic [11:0] ad_iout;
	logic [11:0] ad_vcap;
	logic [11:0] ad_vout;
	logic        pwm, dump, lt3420_charge, arm_led, speaker, speaker_n;
	logic [3:0]  keypad_row;

	int   errors = 0;
	int   checks = 0;
	int   cycles = 0;
	int   fire_t = 0;  // cycles since fire press
	int   i_level = 0; // igniter current while pwm on
	logic press_on = 1'b0;
	int   press_row;
	int   press_col;
	int   n_pulses;
	int   p_start [64];
	int   p_width [64];
	int   p_off [64];

	blaster_top #(.DEBOUNCE_CYC(DEB), .STEP_CYC(STEP), .FIRE_END_CYC(FEND)) UUT (.*);

	always #10 clk = ~clk;

	// positive reading in offset coding
	function automatic logic [11:0] adc_code(input int m);
		return {1'b0, ~11'(m)};
	endfunction

	// on time from min/max rules and the setpoint seen at each decision edge
	function automatic int expected_on_width(input int t0, input int ilvl);
		int sp;
		for (int k = PULSE_MIN_ON; k < PULSE_MAX_ON; k++) begin
			sp = (t0 + k >= STEP + 2 && t0 + k < FEND + 3) ? 4 * DN_PER_AMP : 2 * DN_PER_AMP;
			if (ilvl > sp + CUR_HYST)
				return k;
		end
		return PULSE_MAX_ON;
	endfunction

	// row * 4 + column bit of each key
	function automatic int key_position(input key_code_t code);
		case (code)
			5'h11: return 2;
			5'h12: return 1;
			5'h13: return 0;
			5'h14: return 6;
			5'h15: return 5;
			5'h16: return 4;
			5'h17: return 10;
			5'h18: return 9;
			5'h1A: return 14;
			5'h1B: return 12;
			default: return 13;
		endcase
	endfunction

	function automatic int expected_half_period(input key_code_t code);
		return TONE_HALF[code - KEY_TONE_FIRST] + 1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus side processes

	always @(posedge clk) begin
		fire_t <= fire_button ? fire_t + 1 : 0;
		cycles <= cycles + 1;
	end

	always @(posedge clk) begin
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, a wait on the DUT never completed", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// strobe spacing, current model and keypad model
	initial begin
		ad_strobe  = 1'b0;
		ad_iout    = adc_code(0);
		keypad_col = 3'b111;
		void'($urandom(32'h32ab));
		forever begin
			@(negedge clk);
			ad_strobe  = ($urandom % 4) == 0;
			ad_iout    = pwm ? adc_code(i_level) : adc_code(0); // current only while on
			keypad_col = (press_on && !keypad_row[press_row]) ? ~(3'b001 << press_col) : 3'b111;
		end
	end

	// records every pwm pulse of a firing run
	initial begin
		logic pwm_q;
		int   t_rise;
		int   t_fall;
		logic have_fall;
		pwm_q = 1'b0;
		forever begin
			@(negedge clk);
			if (fire_t == 0) begin
				n_pulses  = 0;
				have_fall = 1'b0;
			end else begin
				if (pwm && !pwm_q)
					t_rise = fire_t;
				if (!pwm && pwm_q && n_pulses < 64) begin
					p_start[n_pulses] = t_rise;
					p_width[n_pulses] = fire_t - t_rise;
					p_off[n_pulses]   = have_fall ? t_rise - t_fall : 0;
					n_pulses++;
					t_fall    = fire_t;
					have_fall = 1'b1;
				end
			end
			pwm_q = pwm;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks and scenario helpers

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("failure: %s", msg);
		errors++;
	endtask

	task automatic apply_reset(input logic [2:0] sw);
		@(negedge clk);
		reset       = 1'b1;
		iset        = sw;
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		ad_vcap     = adc_code(0);
		ad_vout     = adc_code(0);
		press_on    = 1'b0;
		@(negedge clk);
		check("keypad_row", keypad_row, 4'hF);
		@(negedge clk);
		reset = 1'b0;
	endtask

	task automatic wait_fire_cycle(input int t);
		while (fire_t < t)
			@(negedge clk);
	endtask

	task automatic press_key(input key_code_t code);
		press_row = key_position(code) / 4;
		press_col = key_position(code) % 4;
		press_on  = 1'b1;
	endtask

	task automatic measure_tone(input key_code_t code);
		int n;
		press_key(code);
		while (!speaker)
			@(negedge clk);
		check("speaker_n", speaker_n, 1'b0);
		n = 0;
		while (speaker) begin
			@(negedge clk);
			n++;
		end
		check("speaker high time", n, expected_half_period(code));
		check("speaker_n", speaker_n, 1'b1);
		n = 0;
		while (!speaker) begin
			@(negedge clk);
			n++;
		end
		check("speaker low time", n, expected_half_period(code));
		press_on = 1'b0;
		repeat (2 * SCAN + 16) @(negedge clk); // key clears within two scans
		check("speaker", speaker, 1'b0);
		check("speaker_n", speaker_n, 1'b1);
	endtask

	task automatic review_pulses(input int last_start, input bit widths);
		for (int i = 0; i < n_pulses; i++) begin
			if (widths) begin
				check("pwm width", p_width[i], expected_on_width(p_start[i], i_level));
				if (i > 0)
					check("pwm off time", p_off[i], PULSE_MIN_OFF + 1);
			end
			if (p_start[i] > last_start)
				report_failure("a pwm pulse started after it was allowed to");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// scenarios

	initial begin
		int bad;
		int n_short;
		int n_long;
		reset       = 1'b1;
		iset        = 3'b011;
		fire_button = 1'b0;
		lt3420_done = 1'b0;
		ad_vcap     = adc_code(0);
		ad_vout     = adc_code(0);

		// power on charge, then continuity
		apply_reset(3'b011);
		check("lt3420_charge", lt3420_charge, 1'b1);
		check("dump", dump, 1'b0);
		check("pwm", pwm, 1'b0);
		check("speaker", speaker, 1'b0);
		check("arm_led", arm_led, 1'b0);
		lt3420_done = 1'b1;
		@(negedge clk);
		check("lt3420_charge", lt3420_charge, 1'b0);
		lt3420_done = 1'b0;

		// arm hysteresis, 300 V on and 50 V off
		ad_vcap = adc_code(1400);
		repeat (50) @(negedge clk);
		check("arm_led", arm_led, 1'b0);
		ad_vcap = adc_code(1500);
		repeat (50) @(negedge clk);
		check("arm_led", arm_led, 1'b1);
		ad_vcap = adc_code(1000);
		repeat (50) @(negedge clk);
		check("arm_led", arm_led, 1'b1);
		ad_vcap = adc_code(200);
		repeat (50) @(negedge clk);
		check("arm_led", arm_led, 1'b0);
		ad_vcap = adc_code(0);

		// keypad tones, dump and charge keys
		measure_tone(5'h11);
		measure_tone(5'h18);
		press_key(KEY_DUMP);
		while (!dump)
			@(negedge clk);
		press_on = 1'b0;
		while (dump)
			@(negedge clk);
		press_key(KEY_CHARGE);
		while (!lt3420_charge)
			@(negedge clk);
		press_on = 1'b0;
		while (lt3420_charge)
			@(negedge clk);

		// low current firing, then dump
		apply_reset(3'b111);
		i_level     = 0;
		fire_button = 1'b1;
		wait_fire_cycle(FEND + 3 + PULSE_MAX_ON + 10);
		check("dump", dump, 1'b1);
		check("pulse count nonzero", n_pulses > 0 ? 1 : 0, 1);
		bad = 0;
		repeat (2000) begin
			@(negedge clk);
			if (pwm)
				bad = 1;
		end
		check("pwm after window", bad, 0);
		review_pulses(FEND + 1, 1'b1);

		// 600 counts, short pulses at 2 A then long at 4 A
		apply_reset(3'b111);
		i_level     = 600;
		fire_button = 1'b1;
		wait_fire_cycle(FEND + 3 + PULSE_MAX_ON + 10);
		review_pulses(FEND + 1, 1'b1);
		n_short = 0;
		n_long  = 0;
		for (int i = 0; i < n_pulses; i++) begin
			if (p_width[i] == PULSE_MIN_ON && p_start[i] < STEP)
				n_short++;
			if (p_width[i] == PULSE_MAX_ON && p_start[i] > STEP)
				n_long++;
		end
		check("short pulses before step", n_short > 0 ? 1 : 0, 1);
		check("long pulses after step", n_long > 0 ? 1 : 0, 1);

		// burn through from a vout jump
		apply_reset(3'b111);
		i_level     = 0;
		fire_button = 1'b1;
		wait_fire_cycle(BURN_AT);
		ad_vout = adc_code(100);
		wait_fire_cycle(BURN_AT + PULSE_MAX_ON + 64);
		bad = 0;
		while (fire_t < FEND + 1000) begin
			@(negedge clk);
			if (pwm)
				bad = 1;
		end
		check("pwm after burn", bad, 0);
		review_pulses(BURN_AT + 64, 1'b0);

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verilog.f ====
common/blaster_pkg.sv
common/adc_if.sv
src/fire_sequencer.sv
pulse/pulse_controller.sv
pulse/burn_detect.sv
src/key_scan.sv
src/tone_gen.sv
src/blaster_top.sv
dv/blaster_tb.sv

// ==== Makefile ====
# Verilator build for the blaster controller

VERILATOR ?= verilator
TOP       ?= blaster_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
